/* compile.f */
hw/opcodePkg.sv
hw/controlPkg.sv
hw/cycleSequencer.sv
hw/statusFlags.sv
hw/executeDecoder.sv
hw/busCycleDecoder.sv
hw/controlUnit.sv
tb/tbChecker.sv
tb/tbControl.sv

/* hw/busCycleDecoder.sv */
// memory pad pin patterns for instruction fetch, data load and data store
`timescale 1ns/1ps

module busCycleDecoder (
   input  controlPkg::phaseT      phase,
   input  controlPkg::subCycleT   subCycle,
   input  controlPkg::memAccessT  access,
   output logic                   MemEn,
   output logic                   nWE,
   output logic                   nOE,
   output logic                   nME,
   output logic                   ENB,
   output logic                   ALE
);

   import controlPkg::*;

   logic       readCycle;
   logic [2:0] readStep;

   // a load runs the fetch read pattern one cycle later
   assign readCycle = (phase == phFetch) || (access == accLoad && subCycle != cycle0);
   assign readStep = (phase == phFetch) ? subCycle : subCycle - 3'd1;

   always_comb begin
      MemEn = 1'b0;
      nWE = 1'b0;
      nOE = 1'b0;
      nME = 1'b1;
      ENB = 1'b0;
      ALE = 1'b0;
      if (readCycle) begin
         nWE = 1'b1;  // never write during a read
         case (readStep)
            3'd0: begin
               ALE = 1'b1;  // latch address
               nOE = 1'b1;
            end
            3'd1: begin
               nME = 1'b0;
               MemEn = 1'b1;
            end
            3'd2: begin
               nME = 1'b0;
               MemEn = 1'b1;
               ENB = 1'b1;  // read data onto sysbus
            end
            3'd3: MemEn = 1'b1;
            default: ;
         endcase
      end else if (phase == phExecute && access == accStore) begin
         case (subCycle)
            cycle1: begin
               ALE = 1'b1;
               nWE = 1'b1;
               nOE = 1'b1;
            end
            cycle2, cycle3: begin
               nME = 1'b0;  // write strobe with nWE low
               nOE = 1'b1;
            end
            cycle4: nOE = 1'b1;
            default: ;
         endcase
      end
   end

endmodule

/* hw/controlPkg.sv */
// control definitions: datapath selects, sequencer phases, memory access kinds and flags
package controlPkg;

   // status register layout
   typedef logic [3:0] flagsT;

   localparam int flagZ = 0;
   localparam int flagN = 1;
   localparam int flagV = 2;
   localparam int flagC = 3;

   // datapath multiplexer selects
   typedef enum logic {Op1Rd1, Op1Pc} op1SelT;
   typedef enum logic {Op2Imm, Op2Rd2} op2SelT;
   typedef enum logic {WdAlu, WdSys} wdSelT;
   typedef enum logic {ImmLong, ImmShort} immSelT;
   typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus} pcSelT;
   typedef enum logic {LrSys, LrPc} lrSelT;
   typedef enum logic {Rs1Ra, Rs1Rd} rs1SelT;

   // sequencer state
   typedef enum logic {phFetch, phExecute} phaseT;

   typedef enum logic [2:0] {
      cycle0,
      cycle1,
      cycle2,
      cycle3,
      cycle4
   } subCycleT;

   // kind of data memory access in execute
   typedef enum logic [1:0] {accNone, accLoad, accStore} memAccessT;

   localparam int fetchCycles = 4;
   localparam int memExecCycles = 5;  // LDW and STW execute length

endpackage

/* hw/controlUnit.sv */
// control unit top level joining sequencer, flags, execute decoder and bus decoder
`timescale 1ns/1ps

module controlUnit (
   input  logic                   Clock,
   input  logic                   nReset,
   input  opcodePkg::opcodeCondT  OpcodeCondIn,
   input  controlPkg::flagsT      Flags,
   output opcodePkg::aluFnT       AluOp,
   output controlPkg::op1SelT     Op1Sel,
   output controlPkg::op2SelT     Op2Sel,
   output controlPkg::immSelT     ImmSel,
   output controlPkg::wdSelT      WdSel,
   output controlPkg::pcSelT      PcSel,
   output controlPkg::lrSelT      LrSel,
   output controlPkg::rs1SelT     Rs1Sel,
   output logic                   AluEn,
   output logic                   AluWe,
   output logic                   LrEn,
   output logic                   LrWe,
   output logic                   PcWe,
   output logic                   PcEn,
   output logic                   IrWe,
   output logic                   RegWe,
   output logic                   MemEn,
   output logic                   nWE,
   output logic                   nOE,
   output logic                   nME,
   output logic                   ENB,
   output logic                   ALE,
   output logic                   CFlag
);

   import opcodePkg::*;
   import controlPkg::*;

   phaseT     phase;
   subCycleT  subCycle;
   memAccessT access;
   branchT    branchCode;
   logic      statusWe;
   logic      condMet;

   cycleSequencer sequencer (
      .Clock, .nReset, .access, .phase, .subCycle
   );

   statusFlags flags (
      .Clock, .nReset, .Flags, .statusWe, .BranchCode(branchCode), .condMet, .CFlag
   );

   executeDecoder decoder (
      .OpcodeCondIn, .phase, .subCycle, .condMet,
      .AluOp, .Op1Sel, .Op2Sel, .ImmSel, .WdSel, .PcSel, .LrSel, .Rs1Sel,
      .AluEn, .AluWe, .LrEn, .LrWe, .PcWe, .PcEn, .IrWe, .RegWe, .statusWe,
      .access, .BranchCode(branchCode)
   );

   busCycleDecoder busPins (
      .phase, .subCycle, .access, .MemEn, .nWE, .nOE, .nME, .ENB, .ALE
   );

endmodule

/* hw/cycleSequencer.sv */
// phase sequencer stepping each instruction through fetch and execute sub-cycles
`timescale 1ns/1ps

module cycleSequencer (
   input  logic                  Clock,
   input  logic                  nReset,
   input  controlPkg::memAccessT access,
   output controlPkg::phaseT     phase,
   output controlPkg::subCycleT  subCycle
);

   import controlPkg::*;

   subCycleT nextSub;

   assign nextSub = subCycleT'(subCycle + 3'd1);

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         phase <= phFetch;
         subCycle <= cycle0;
      end else if (phase == phFetch) begin
         if (subCycle == subCycleT'(fetchCycles - 1)) begin
            phase <= phExecute;  // instruction now in IR
            subCycle <= cycle0;
         end else begin
            subCycle <= nextSub;
         end
      end else begin
         case (subCycle)
            cycle0: begin
               if (access == accNone) begin
                  phase <= phFetch;  // single cycle execute
               end else begin
                  subCycle <= cycle1;
               end
            end
            cycle1, cycle2, cycle3: subCycle <= nextSub;
            default: begin
               // last memory cycle, or an illegal count
               phase <= phFetch;
               subCycle <= cycle0;
            end
         endcase
      end
   end

endmodule

/* hw/executeDecoder.sv */
// opcode decoder producing datapath controls for every phase and sub-cycle
`timescale 1ns/1ps

module executeDecoder (
   input  opcodePkg::opcodeCondT  OpcodeCondIn,
   input  controlPkg::phaseT      phase,
   input  controlPkg::subCycleT   subCycle,
   input  logic                   condMet,
   output opcodePkg::aluFnT       AluOp,
   output controlPkg::op1SelT     Op1Sel,
   output controlPkg::op2SelT     Op2Sel,
   output controlPkg::immSelT     ImmSel,
   output controlPkg::wdSelT      WdSel,
   output controlPkg::pcSelT      PcSel,
   output controlPkg::lrSelT      LrSel,
   output controlPkg::rs1SelT     Rs1Sel,
   output logic                   AluEn,
   output logic                   AluWe,
   output logic                   LrEn,
   output logic                   LrWe,
   output logic                   PcWe,
   output logic                   PcEn,
   output logic                   IrWe,
   output logic                   RegWe,
   output logic                   statusWe,
   output controlPkg::memAccessT  access,
   output opcodePkg::branchT      BranchCode
);

   import opcodePkg::*;
   import controlPkg::*;

   opcodeT opcode;

   assign opcode = opcodeT'(OpcodeCondIn[opcodeWidth+condWidth-1:condWidth]);
   assign BranchCode = branchT'(OpcodeCondIn[condWidth-1:0]);

   assign access = (opcode == LDW) ? accLoad : (opcode == STW) ? accStore : accNone;

   // ALU function for the single cycle arithmetic and logic group
   function automatic aluFnT aluFunction(opcodeT op);
      case (op)
         ADD, ADDI, ADDIB:      return FnADD;
         ADC, ADCI, SUC, SUCI:  return FnADC;
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG:  return FnNEG;
         AND:  return FnAND;
         OR:   return FnOR;
         XOR:  return FnXOR;
         NOT:  return FnNOT;
         NAND: return FnNAND;
         NOR:  return FnNOR;
         LSL:  return FnLSL;
         LSR:  return FnLSR;
         ASR:  return FnASR;
         default: return FnA;
      endcase
   endfunction

   always_comb begin
      AluOp = FnA;
      Op1Sel = Op1Rd1;
      Op2Sel = Op2Imm;
      ImmSel = ImmLong;
      WdSel = WdAlu;
      PcSel = Pc1;
      LrSel = LrSys;
      Rs1Sel = Rs1Ra;
      AluEn = 1'b0;
      AluWe = 1'b0;
      LrEn = 1'b0;
      LrWe = 1'b0;
      PcWe = 1'b0;
      PcEn = 1'b0;
      IrWe = 1'b0;
      RegWe = 1'b0;
      statusWe = 1'b0;
      if (phase == phFetch) begin
         PcEn = (subCycle == cycle0);  // PC onto the address bus
         IrWe = (subCycle == cycle3);
      end else begin
         case (subCycle)
            cycle0: begin
               case (opcode)
                  ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, CMP, CMPI,
                  AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, NEG: begin
                     AluOp = aluFunction(opcode);
                     PcEn = 1'b1;
                     PcWe = 1'b1;
                     statusWe = 1'b1;
                     RegWe = !(opcode inside {CMP, CMPI});  // compare only sets flags
                     if (opcode inside {ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR})
                        Op2Sel = Op2Rd2;
                     if (opcode inside {ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR})
                        ImmSel = ImmShort;
                     if (opcode inside {ADDIB, SUBIB})
                        Rs1Sel = Rs1Rd;  // byte forms read the destination
                  end
                  LUI, LLI: begin
                     AluOp = (opcode == LUI) ? FnLUI : FnLLI;
                     Rs1Sel = Rs1Rd;  // keeps the other byte of Rd
                     AluEn = 1'b1;
                     RegWe = 1'b1;
                     PcWe = 1'b1;
                  end
                  LDW, STW: begin
                     AluOp = FnADD;  // base plus offset
                     ImmSel = ImmShort;
                     AluEn = 1'b1;
                     AluWe = 1'b1;
                  end
                  BRANCH: begin
                     PcWe = 1'b1;
                     case (BranchCode)
                        RET: begin
                           LrEn = 1'b1;  // link register onto sysbus
                           PcSel = PcSysbus;
                        end
                        JMP: begin
                           AluOp = FnADD;
                           ImmSel = ImmShort;
                           PcSel = PcAluOut;
                        end
                        default: begin
                           AluOp = FnADD;  // PC relative target
                           Op1Sel = Op1Pc;
                           AluEn = 1'b1;
                           if (condMet) begin
                              PcSel = PcAluOut;
                              LrWe = (BranchCode == BWL);
                              LrSel = LrPc;
                           end
                        end
                     endcase
                  end
                  default: ;
               endcase
            end
            cycle1: begin
               AluOp = FnADD;  // address held on sysbus
               ImmSel = ImmShort;
               AluEn = 1'b1;
            end
            cycle2: begin
               AluOp = FnA;  // pass Rd through for the store data
               Rs1Sel = Rs1Rd;
               AluEn = 1'b1;
               AluWe = 1'b1;
            end
            cycle3: AluEn = (opcode == STW);
            cycle4: begin
               PcWe = 1'b1;
               AluEn = (opcode == STW);
               if (opcode == LDW) begin
                  WdSel = WdSys;  // read data into Rd
                  RegWe = 1'b1;
               end
            end
            default: ;
         endcase
      end
   end

endmodule

/* hw/opcodePkg.sv */
// instruction set definitions: opcodes, branch codes, ALU functions and field widths
package opcodePkg;

   localparam int opcodeWidth = 5;
   localparam int condWidth = 3;

   typedef logic [opcodeWidth+condWidth-1:0] opcodeCondT;  // opcode over branch code

   typedef enum logic [opcodeWidth-1:0] {
      ADD    = 5'd0,
      ADDI   = 5'd1,
      ADDIB  = 5'd2,
      ADC    = 5'd3,
      ADCI   = 5'd4,
      SUB    = 5'd5,
      SUBI   = 5'd6,
      SUBIB  = 5'd7,
      SUC    = 5'd8,
      SUCI   = 5'd9,
      CMP    = 5'd10,
      CMPI   = 5'd11,
      AND    = 5'd12,
      OR     = 5'd13,
      XOR    = 5'd14,
      NOT    = 5'd15,
      NAND   = 5'd16,
      NOR    = 5'd17,
      LSL    = 5'd18,
      LSR    = 5'd19,
      ASR    = 5'd20,
      NEG    = 5'd21,
      LUI    = 5'd22,
      LLI    = 5'd23,
      LDW    = 5'd24,
      STW    = 5'd25,
      BRANCH = 5'd26  // subtype in the branch code field
   } opcodeT;

   typedef enum logic [condWidth-1:0] {BR, BNE, BE, BLT, BGE, BWL, RET, JMP} branchT;

   typedef enum logic [3:0] {
      FnA, FnADD, FnADC, FnSUB, FnNEG, FnAND, FnOR, FnXOR,
      FnNOT, FnNAND, FnNOR, FnLSL, FnLSR, FnASR, FnLUI, FnLLI
   } aluFnT;

endpackage

/* hw/statusFlags.sv */
// status flag register and branch condition evaluation
`timescale 1ns/1ps

module statusFlags (
   input  logic               Clock,
   input  logic               nReset,
   input  controlPkg::flagsT  Flags,
   input  logic               statusWe,
   input  opcodePkg::branchT  BranchCode,
   output logic               condMet,
   output logic               CFlag
);

   import controlPkg::*;
   import opcodePkg::*;

   flagsT statusReg;

   always_ff @(posedge Clock or negedge nReset) begin
      if (!nReset) begin
         statusReg <= '0;
      end else if (statusWe) begin
         statusReg <= Flags;  // from ALU result
      end
   end

   assign CFlag = statusReg[flagC];

   always_comb begin
      case (BranchCode)
         BR, BWL: condMet = 1'b1;
         BNE:     condMet = !statusReg[flagZ];
         BE:      condMet = statusReg[flagZ];
         BLT:     condMet = statusReg[flagN] ^ statusReg[flagV];  // signed less than
         BGE:     condMet = !(statusReg[flagN] ^ statusReg[flagV]);
         default: condMet = 1'b0;  // RET and JMP ignore flags
      endcase
   end

endmodule

/* tb/tbChecker.sv */
// output checker modelling the fetch and execute sequence and comparing the DUT every cycle
`timescale 1ns/1ps

module tbChecker (
   input  logic                   Clock,
   input  logic                   nReset,
   input  opcodePkg::opcodeCondT  OpcodeCondIn,
   input  controlPkg::flagsT      Flags,
   input  opcodePkg::aluFnT       AluOp,
   input  controlPkg::op1SelT     Op1Sel,
   input  controlPkg::op2SelT     Op2Sel,
   input  controlPkg::immSelT     ImmSel,
   input  controlPkg::wdSelT      WdSel,
   input  controlPkg::pcSelT      PcSel,
   input  controlPkg::lrSelT      LrSel,
   input  controlPkg::rs1SelT     Rs1Sel,
   input  logic                   AluEn,
   input  logic                   AluWe,
   input  logic                   LrEn,
   input  logic                   LrWe,
   input  logic                   PcWe,
   input  logic                   PcEn,
   input  logic                   IrWe,
   input  logic                   RegWe,
   input  logic                   MemEn,
   input  logic                   nWE,
   input  logic                   nOE,
   input  logic                   nME,
   input  logic                   ENB,
   input  logic                   ALE,
   input  logic                   CFlag,
   output int                     errors,
   output int                     checks
);

   import opcodePkg::*;
   import controlPkg::*;

   logic        inExec;
   int          step;
   flagsT       modelFlags;  // status register as the ISA defines it
   opcodeT      op;
   opcodeT      execOp;  // last instruction that went through execute
   logic        started;
   int          gap;
   logic [26:0] expected;
   logic [26:0] actual;

   function automatic logic aluGroup(opcodeT code);
      return !(code inside {LUI, LLI, LDW, STW, BRANCH});
   endfunction

   function automatic int instrLength(opcodeT code);
      return fetchCycles + ((code inside {LDW, STW}) ? memExecCycles : 1);
   endfunction

   function automatic aluFnT aluFunction(opcodeT code);
      case (code)
         ADD, ADDI, ADDIB: return FnADD;
         ADC, ADCI, SUC, SUCI: return FnADC;  // carry forms share the carry adder
         SUB, SUBI, SUBIB, CMP, CMPI: return FnSUB;
         NEG: return FnNEG;
         AND: return FnAND;
         OR: return FnOR;
         XOR: return FnXOR;
         NOT: return FnNOT;
         NAND: return FnNAND;
         NOR: return FnNOR;
         LSL: return FnLSL;
         LSR: return FnLSR;
         default: return FnASR;
      endcase
   endfunction

   // MemEn nWE nOE nME ENB ALE for each step of a read
   function automatic logic [5:0] readPins(int readStep);
      case (readStep)
         0: return 6'b011101;  // address latch
         1: return 6'b110000;
         2: return 6'b110010;  // data on sysbus
         default: return 6'b110100;
      endcase
   endfunction

   function automatic logic [26:0] expectedOutputs(logic exec, int sc, opcodeCondT instr,
                                                  flagsT fl);
      opcodeT     code;
      branchT     cond;
      logic       taken;
      logic [3:0] fn;
      logic [1:0] pc;
      logic       op1, op2, imm, wd, lr, rs1;
      logic       aluEn, aluWe, lrEn, lrWe, pcWe, pcEn, irWe, regWe;
      logic [5:0] pins;
      code = opcodeT'(instr[opcodeWidth+condWidth-1:condWidth]);
      cond = branchT'(instr[condWidth-1:0]);
      case (cond)
         BNE: taken = !fl[flagZ];
         BE: taken = fl[flagZ];
         BLT: taken = fl[flagN] != fl[flagV];
         BGE: taken = fl[flagN] == fl[flagV];
         default: taken = 1'b1;  // BR and BWL always go
      endcase
      fn = FnA;
      op1 = Op1Rd1;
      op2 = Op2Imm;
      imm = ImmLong;
      wd = WdAlu;
      pc = Pc1;
      lr = LrSys;
      rs1 = Rs1Ra;
      {aluEn, aluWe, lrEn, lrWe, pcWe, pcEn, irWe, regWe} = '0;
      pins = 6'b000100;  // bus idle
      if (!exec) begin
         pcEn = (sc == 0);
         irWe = (sc == fetchCycles - 1);
         pins = readPins(sc);
      end else if (sc == 0) begin
         if (code inside {LUI, LLI}) begin
            fn = (code == LUI) ? FnLUI : FnLLI;
            rs1 = Rs1Rd;
            {aluEn, regWe, pcWe} = 3'b111;
         end else if (code inside {LDW, STW}) begin
            fn = FnADD;  // effective address
            imm = ImmShort;
            {aluEn, aluWe} = 2'b11;
         end else if (code == BRANCH) begin
            pcWe = 1'b1;
            if (cond == RET) begin
               lrEn = 1'b1;
               pc = PcSysbus;
            end else if (cond == JMP) begin
               fn = FnADD;
               imm = ImmShort;
               pc = PcAluOut;
            end else begin
               fn = FnADD;
               op1 = Op1Pc;
               aluEn = 1'b1;
               if (taken) begin
                  pc = PcAluOut;
                  lr = LrPc;
                  lrWe = (cond == BWL);
               end
            end
         end else begin
            fn = aluFunction(code);
            {pcEn, pcWe} = 2'b11;
            regWe = !(code inside {CMP, CMPI});
            if (code inside {ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR})
               op2 = Op2Rd2;
            if (code inside {ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR})
               imm = ImmShort;
            if (code inside {ADDIB, SUBIB})
               rs1 = Rs1Rd;
         end
      end else begin
         case (sc)
            1: begin
               fn = FnADD;
               imm = ImmShort;
               aluEn = 1'b1;
            end
            2: begin
               rs1 = Rs1Rd;  // store data path
               {aluEn, aluWe} = 2'b11;
            end
            3: aluEn = (code == STW);
            default: begin
               pcWe = 1'b1;
               aluEn = (code == STW);
               if (code == LDW) begin
                  wd = WdSys;
                  regWe = 1'b1;
               end
            end
         endcase
         if (code == LDW)
            pins = readPins(sc - 1);
         else if (sc == 1)
            pins = 6'b011101;
         else if (sc == 4)
            pins = 6'b001100;
         else
            pins = 6'b001000;  // write strobe
      end
      return {fn, op1, op2, imm, wd, pc, lr, rs1, aluEn, aluWe, lrEn, lrWe, pcWe, pcEn, irWe,
              regWe, pins, fl[flagC]};
   endfunction

   initial begin
      errors = 0;
      checks = 0;
   end

   always @(negedge Clock) begin : compareOutputs
      op = opcodeT'(OpcodeCondIn[opcodeWidth+condWidth-1:condWidth]);
      if (!nReset) begin
         inExec = 1'b0;
         step = 0;
         modelFlags = '0;
         started = 1'b0;
         gap = 0;
      end
      expected = expectedOutputs(inExec, step, OpcodeCondIn, modelFlags);
      actual = {AluOp, Op1Sel, Op2Sel, ImmSel, WdSel, PcSel, LrSel, Rs1Sel, AluEn, AluWe,
                LrEn, LrWe, PcWe, PcEn, IrWe, RegWe, MemEn, nWE, nOE, nME, ENB, ALE, CFlag};
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("error at time %0t: outputs %h, expected %h (%s cycle %0d, instr %h)",
                  $time, actual, expected, inExec ? "execute" : "fetch", step, OpcodeCondIn);
      end
      if (nReset) begin
         gap++;
         if (IrWe) begin
            if (started && gap != instrLength(execOp)) begin
               errors++;
               $display("error at time %0t: %0d cycles between fetches, expected %0d",
                        $time, gap, instrLength(execOp));
            end
            started = 1'b1;
            gap = 0;
         end
         if (!inExec) begin
            step++;
            if (step == fetchCycles) begin
               inExec = 1'b1;
               step = 0;
            end
         end else begin
            if (step == 0) begin
               execOp = op;
               if (aluGroup(op))
                  modelFlags = Flags;  // loaded at the edge ending cycle0
            end
            if (step == ((op inside {LDW, STW}) ? memExecCycles - 1 : 0)) begin
               inExec = 1'b0;
               step = 0;
            end else begin
               step++;
            end
         end
      end
   end

endmodule

/* tb/tbControl.sv */
// testbench top running random and directed instruction streams through the control unit
`timescale 1ns/1ps

module tbControl;

   import opcodePkg::*;
   import controlPkg::*;

   localparam int randomCount = 200;
   localparam int branchCount = 128;  // CMP and branch pairs
   localparam int linkCount = 12;
   localparam int memCount = 16;
   localparam int numInstr = randomCount + branchCount + linkCount + memCount + 8;
   localparam int timeLimit = (numInstr * 9 + 100) * 8;

   logic       Clock;
   logic       nReset;
   opcodeCondT OpcodeCondIn;
   flagsT      Flags;
   aluFnT      AluOp;
   op1SelT     Op1Sel;
   op2SelT     Op2Sel;
   immSelT     ImmSel;
   wdSelT      WdSel;
   pcSelT      PcSel;
   lrSelT      LrSel;
   rs1SelT     Rs1Sel;
   logic       AluEn, AluWe, LrEn, LrWe, PcWe, PcEn, IrWe, RegWe;
   logic       MemEn, nWE, nOE, nME, ENB, ALE, CFlag;
   int         errors;
   int         checks;

   integer     seed;
   opcodeCondT instrQ[$];
   logic [4:0] flagsQ[$];  // bit 4 set means random flags
   logic [4:0] flagsMode;
   logic       fetchDone;
   int         testCount;
   int         failedTests;
   int         lastErrors;

   controlUnit uut (
      .Clock, .nReset, .OpcodeCondIn, .Flags,
      .AluOp, .Op1Sel, .Op2Sel, .ImmSel, .WdSel, .PcSel, .LrSel, .Rs1Sel,
      .AluEn, .AluWe, .LrEn, .LrWe, .PcWe, .PcEn, .IrWe, .RegWe,
      .MemEn, .nWE, .nOE, .nME, .ENB, .ALE, .CFlag
   );

   tbChecker outputCheck (
      .Clock, .nReset, .OpcodeCondIn, .Flags,
      .AluOp, .Op1Sel, .Op2Sel, .ImmSel, .WdSel, .PcSel, .LrSel, .Rs1Sel,
      .AluEn, .AluWe, .LrEn, .LrWe, .PcWe, .PcEn, .IrWe, .RegWe,
      .MemEn, .nWE, .nOE, .nME, .ENB, .ALE, .CFlag, .errors, .checks
   );

   always #4 Clock = ~Clock;

   // next instruction goes out in the cycle after IrWe
   always begin : driveInputs
      @(negedge Clock);
      fetchDone = IrWe;
      @(posedge Clock);
      #1;
      if (fetchDone) begin
         if (instrQ.size() > 0) begin
            OpcodeCondIn = instrQ.pop_front();
            flagsMode = flagsQ.pop_front();
         end else begin
            OpcodeCondIn = {ADD, 3'b000};  // filler between tests
            flagsMode = 5'h10;
         end
      end
      Flags = flagsMode[4] ? flagsT'($random(seed)) : flagsMode[3:0];
   end

   task automatic pushInstr(input opcodeT op, input logic [2:0] code, input logic [4:0] mode);
      instrQ.push_back({op, code});
      flagsQ.push_back(mode);
   endtask

   task automatic randomStream();
      logic [31:0] r;
      opcodeT      op;
      logic [2:0]  code;
      for (int i = 0; i < randomCount; i++) begin
         r = $random(seed);
         code = r[2:0];
         if (i < 26) begin
            op = opcodeT'(i);  // each non branch opcode once
         end else if (i < 34) begin
            op = BRANCH;
            code = 3'(i - 26);  // each branch code once
         end else if (r[5:4] == 2'b00) begin
            op = BRANCH;
         end else begin
            op = opcodeT'(r[15:8] % 26);
         end
         pushInstr(op, code, 5'h10);
      end
   endtask

   task automatic finishTest(input string name);
      while (instrQ.size() > 0)
         @(posedge Clock);
      do
         @(negedge Clock);
      while (!IrWe);  // last queued instruction has left execute
      @(posedge Clock);
      testCount++;
      if (errors == lastErrors) begin
         $display("test %0d, %s: ok", testCount, name);
      end else begin
         failedTests++;
         $display("test %0d, %s: %0d errors", testCount, name, errors - lastErrors);
      end
      lastErrors = errors;
   endtask

   initial begin : runTests
      seed = 32'hdc4d_b2ed;
      Clock = 1'b0;
      nReset = 1'b0;
      OpcodeCondIn = '0;
      Flags = '0;
      flagsMode = 5'h10;
      testCount = 0;
      failedTests = 0;
      lastErrors = 0;
      randomStream();
      repeat (4) @(posedge Clock);
      #1 nReset = 1'b1;
      finishTest("reset and random stream");
      for (int f = 0; f < 16; f++) begin
         for (int c = 1; c <= 4; c++) begin  // BNE, BE, BLT, BGE
            pushInstr(CMP, 3'b000, {1'b0, 4'(f)});
            pushInstr(BRANCH, 3'(c), 5'h10);
         end
      end
      finishTest("compare and branch");
      for (int i = 0; i < linkCount / 3; i++) begin
         pushInstr(BRANCH, BWL, 5'h10);
         pushInstr(BRANCH, RET, 5'h10);
         pushInstr(BRANCH, JMP, 5'h10);
      end
      finishTest("link, return and jump");
      for (int i = 0; i < memCount / 2; i++) begin
         pushInstr(LDW, 3'(i), 5'h10);
         pushInstr(STW, 3'(i), 5'h10);
      end
      finishTest("load and store");
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               testCount, failedTests, checks, errors);
      if (failedTests == 0 && errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(timeLimit);
      $display("timeout: the run did not finish within %0d ns", timeLimit);
      $display("Some tests failed");
      $finish;
   end

endmodule
